/* logic/race_pkg.sv */
package race_pkg;

    typedef logic [9:0]  coord_t;
    typedef logic [12:0] cell_addr_t;
    typedef logic [1:0]  cell_color_t;  // 0 road, 1 grass, 2 kerb, 3 wall
    typedef logic [11:0] rgb_t;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        SETTING   = 3'd1,
        COUNTDOWN = 3'd3,
        RACING    = 3'd4,
        PAUSE     = 3'd5,
        FINISH    = 3'd6
    } game_state_t;

    // 640x480 at 25 MHz
    localparam int H_ACTIVE = 640, H_TOTAL = 800, H_SYNC_START = 656, H_SYNC_LEN = 96;
    localparam int V_ACTIVE = 480, V_TOTAL = 525, V_SYNC_START = 490, V_SYNC_LEN = 2;

    // screen layout
    localparam int HALF_W = 320, HUD_TOP = 360, MINIMAP_X0 = 240, MINIMAP_X1 = 400;
    localparam int VIEW_OFS_X = 40, VIEW_OFS_Y = 45, SELF_CX = 160, SELF_CY = 180;
    localparam int CAR_HALF = 37, DOT_HALF = 6;
    localparam int MAP_W_CELLS = 80, MAP_H_CELLS = 60, CELL_SHIFT = 3;  // 8 units per cell
    localparam int MAP_W = 640, MAP_H = 480;

    localparam rgb_t COL_LOBBY = 12'hBEB, COL_FINISH = 12'h222, COL_SEPARATOR = 12'hFFF;
    localparam rgb_t COL_HUD = 12'h444, COL_OUT_BOUND = 12'h6B4;
    localparam rgb_t COL_P1 = 12'hF00, COL_P2 = 12'h00F;
    localparam rgb_t COL_P1_WIN = 12'hFAA, COL_P2_WIN = 12'hAAF;
    localparam rgb_t PALETTE [0:3] = '{12'h888, 12'h2A2, 12'hFFF, 12'h000};

    localparam int PIPE_LATENCY = 2;  // scan position to rgb

    // bit positions in the pixel flag word
    localparam int FLAG_OUT_OF_MAP = 4, FLAG_SELF_BOX = 3, FLAG_ENEMY_BOX = 2;
    localparam int FLAG_P1_DOT = 1, FLAG_P2_DOT = 0;

endpackage

/* logic/scan_if.sv */
`timescale 1ns/10ps

interface scan_if import race_pkg::*; ();

    coord_t x;
    coord_t y;
    logic   active;     // inside the 640x480 window
    logic   left_half;  // player 1 side

    modport source (
        output x, y, active, left_half
    );

    modport sink (
        input x, y, active, left_half
    );

endinterface

/* logic/vga_timing.sv */
`timescale 1ns/10ps

module vga_timing import race_pkg::*; (
    input  logic   clk_25MHz,
    input  logic   rst,
    scan_if.source scan,
    output logic   hsync,
    output logic   vsync
);

    coord_t h_cnt;
    coord_t v_cnt;
    logic   h_wrap;

    assign h_wrap = (h_cnt == coord_t'(H_TOTAL - 1));

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_wrap) begin
                h_cnt <= '0;
                // next line, or back to top of frame
                if (v_cnt == coord_t'(V_TOTAL - 1)) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    assign scan.x         = h_cnt;
    assign scan.y         = v_cnt;
    assign scan.active    = (h_cnt < coord_t'(H_ACTIVE)) && (v_cnt < coord_t'(V_ACTIVE));
    assign scan.left_half = (h_cnt < coord_t'(HALF_W));

    // raw active-low syncs that the mixer aligns later
    assign hsync = !((h_cnt >= coord_t'(H_SYNC_START)) &&
                     (h_cnt < coord_t'(H_SYNC_START + H_SYNC_LEN)));
    assign vsync = !((v_cnt >= coord_t'(V_SYNC_START)) &&
                     (v_cnt < coord_t'(V_SYNC_START + V_SYNC_LEN)));

endmodule

/* logic/game_fsm.sv */
`timescale 1ns/10ps

module game_fsm import race_pkg::*; #(
    parameter int COUNT_TICKS = 25_000_000
) (
    input  logic        clk_25MHz,
    input  logic        rst,
    input  logic        start_btn,
    input  logic        setting_btn,
    input  logic        pause_btn,
    input  logic        p1_finish,
    input  logic        p2_finish,
    output game_state_t state
);

    localparam int TICK_W = $clog2(COUNT_TICKS + 1);

    logic [2:0]        btn_q;     // start, setting, pause
    logic [2:0]        btn_rise;
    logic [TICK_W-1:0] tick_cnt;
    logic [1:0]        phase;     // 2, 1, 0 then race
    logic              tick_end;

    assign btn_rise = {start_btn, setting_btn, pause_btn} & ~btn_q;
    assign tick_end = (tick_cnt == TICK_W'(COUNT_TICKS - 1));

    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            state    <= IDLE;
            btn_q    <= '0;
            tick_cnt <= '0;
            phase    <= '0;
        end else begin
            btn_q <= {start_btn, setting_btn, pause_btn};
            case (state)
                IDLE, SETTING: begin
                    if (btn_rise[2]) begin
                        state    <= COUNTDOWN;
                        tick_cnt <= '0;
                        phase    <= 2'd2;
                    end else if (btn_rise[1]) begin
                        state <= (state == IDLE) ? SETTING : IDLE;
                    end
                end
                COUNTDOWN: begin
                    tick_cnt <= tick_end ? '0 : tick_cnt + 1'b1;
                    if (tick_end) begin
                        if (phase == 2'd0) state <= RACING;
                        else phase <= phase - 1'b1;
                    end
                end
                RACING: begin
                    if (p1_finish && p2_finish) state <= FINISH;  // both must cross
                    else if (btn_rise[0]) state <= PAUSE;
                end
                PAUSE: begin
                    if (btn_rise[0]) state <= RACING;
                end
                FINISH: begin
                    if (btn_rise[2]) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* logic/map_ram.sv */
`timescale 1ns/10ps

module map_ram import race_pkg::*; (
    input  logic        clk_25MHz,
    input  logic        rst,
    input  cell_addr_t  view_addr,
    input  cell_addr_t  mini_addr,
    output cell_color_t view_cell,
    output cell_color_t mini_cell,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  cell_addr_t  wb_adr,
    input  logic [7:0]  wb_wdata,
    output logic [7:0]  wb_rdata,
    output logic        wb_ack
);

    localparam int CELLS = MAP_W_CELLS * MAP_H_CELLS;

    cell_color_t mem [0:CELLS-1];
    logic        access;

    initial begin
        for (int i = 0; i < CELLS; i++) begin
            mem[i] = '0;  // blank track of road
        end
    end

    // one access per strobe with ack low for a cycle in between
    assign access = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk_25MHz) begin
        view_cell <= mem[view_addr];
        mini_cell <= mem[mini_addr];
        if (access && wb_we) mem[wb_adr] <= wb_wdata[1:0];
        if (access && !wb_we) wb_rdata <= {6'b0, mem[wb_adr]};  // host read port
    end

    always_ff @(posedge clk_25MHz) begin
        if (rst) wb_ack <= 1'b0;
        else wb_ack <= access;
    end

endmodule

/* logic/view_addr_gen.sv */
`timescale 1ns/10ps

module view_addr_gen import race_pkg::*; (
    scan_if.sink       scan,
    input  coord_t     p1_x,
    input  coord_t     p1_y,
    input  coord_t     p2_x,
    input  coord_t     p2_y,
    output cell_addr_t view_addr,
    output cell_addr_t mini_addr,
    output logic [4:0] flags
);

    // player within DOT_HALF world units of a minimap point
    function automatic logic near(coord_t a, coord_t b);
        logic signed [10:0] d;
        d = $signed({1'b0, a}) - $signed({1'b0, b});
        return (d >= -$signed(11'(DOT_HALF))) && (d <= $signed(11'(DOT_HALF)));
    endfunction

    coord_t             my_x, my_y, rival_x, rival_y;
    coord_t             view_x;
    coord_t             map_x, map_y;   // world point under the pixel
    coord_t             mm_x, mm_y;     // world point under the minimap pixel
    logic               out_of_map, in_mini;
    logic signed [12:0] dx, dy, ex_c, ey_c, sx, sy;
    logic               self_box, enemy_box;

    assign my_x    = scan.left_half ? p1_x : p2_x;
    assign my_y    = scan.left_half ? p1_y : p2_y;
    assign rival_x = scan.left_half ? p2_x : p1_x;
    assign rival_y = scan.left_half ? p2_y : p1_y;
    assign view_x  = scan.left_half ? scan.x : scan.x - coord_t'(HALF_W);

    // 4x zoom around the player
    assign map_x = coord_t'(view_x >> 2) + my_x - coord_t'(VIEW_OFS_X);
    assign map_y = coord_t'(scan.y >> 2) + my_y - coord_t'(VIEW_OFS_Y);
    assign out_of_map = (map_x >= coord_t'(MAP_W)) || (map_y >= coord_t'(MAP_H));
    assign view_addr = out_of_map ? '0 :
        cell_addr_t'(map_y >> CELL_SHIFT) * cell_addr_t'(MAP_W_CELLS) +
        cell_addr_t'(map_x >> CELL_SHIFT);

    assign self_box = (view_x >= coord_t'(SELF_CX - CAR_HALF)) &&
                      (view_x <= coord_t'(SELF_CX + CAR_HALF)) &&
                      (scan.y >= coord_t'(SELF_CY - CAR_HALF)) &&
                      (scan.y <= coord_t'(SELF_CY + CAR_HALF));

    // rival offset can be negative
    assign dx   = $signed({3'b000, rival_x}) - $signed({3'b000, my_x});
    assign dy   = $signed({3'b000, rival_y}) - $signed({3'b000, my_y});
    assign ex_c = $signed(13'(SELF_CX)) + (dx <<< 2);
    assign ey_c = $signed(13'(SELF_CY)) + (dy <<< 2);
    assign sx   = $signed({3'b000, view_x});
    assign sy   = $signed({3'b000, scan.y});
    assign enemy_box = (sx >= ex_c - $signed(13'(CAR_HALF))) &&
                       (sx <= ex_c + $signed(13'(CAR_HALF))) &&
                       (sy >= ey_c - $signed(13'(CAR_HALF))) &&
                       (sy <= ey_c + $signed(13'(CAR_HALF)));

    assign in_mini = scan.active && (scan.y >= coord_t'(HUD_TOP)) &&
                     (scan.x >= coord_t'(MINIMAP_X0)) && (scan.x < coord_t'(MINIMAP_X1));
    assign mm_x = (scan.x - coord_t'(MINIMAP_X0)) << 2;  // whole map in 160x120
    assign mm_y = (scan.y - coord_t'(HUD_TOP)) << 2;
    assign mini_addr = !in_mini ? '0 :
        cell_addr_t'(mm_y >> CELL_SHIFT) * cell_addr_t'(MAP_W_CELLS) +
        cell_addr_t'(mm_x >> CELL_SHIFT);

    always_comb begin
        flags                  = '0;
        flags[FLAG_OUT_OF_MAP] = out_of_map;
        flags[FLAG_SELF_BOX]   = self_box;
        flags[FLAG_ENEMY_BOX]  = enemy_box;
        flags[FLAG_P1_DOT]     = in_mini && near(mm_x, p1_x) && near(mm_y, p1_y);
        flags[FLAG_P2_DOT]     = in_mini && near(mm_x, p2_x) && near(mm_y, p2_y);
    end

endmodule

/* logic/pixel_mixer.sv */
`timescale 1ns/10ps

module pixel_mixer import race_pkg::*; (
    input  logic        clk_25MHz,
    input  logic        rst,
    scan_if.sink        scan,
    input  logic        hsync_raw,
    input  logic        vsync_raw,
    input  game_state_t state,
    input  logic        p1_finish,
    input  logic        p2_finish,
    input  logic [4:0]  flags,
    input  cell_color_t view_cell,
    input  cell_color_t mini_cell,
    output rgb_t        rgb,
    output logic        hsync,
    output logic        vsync
);

    logic [PIPE_LATENCY-1:0] hs_pipe, vs_pipe;
    logic [4:0]              flags_q;
    coord_t                  x_q, y_q;
    logic                    active_q, left_q;
    logic                    tinted;
    rgb_t                    pix;

    // stage one lines up with the registered ram reads
    always_ff @(posedge clk_25MHz) begin
        if (rst) begin
            hs_pipe  <= '1;
            vs_pipe  <= '1;
            active_q <= 1'b0;
        end else begin
            hs_pipe  <= {hs_pipe[PIPE_LATENCY-2:0], hsync_raw};
            vs_pipe  <= {vs_pipe[PIPE_LATENCY-2:0], vsync_raw};
            active_q <= scan.active;
        end
    end

    always_ff @(posedge clk_25MHz) begin
        flags_q <= flags;
        x_q     <= scan.x;
        y_q     <= scan.y;
        left_q  <= scan.left_half;
    end

    assign tinted = (state == RACING || state == PAUSE) &&
                    ((left_q && p1_finish) || (!left_q && p2_finish));

    always_comb begin
        if (!active_q) pix = 12'h000;
        else if (state == IDLE) pix = COL_LOBBY;
        else if (state == FINISH) pix = COL_FINISH;
        else if (y_q == coord_t'(HUD_TOP - 1) || y_q == coord_t'(HUD_TOP)) pix = COL_SEPARATOR;
        else if (y_q > coord_t'(HUD_TOP)) begin
            if (flags_q[FLAG_P1_DOT]) pix = COL_P1;
            else if (flags_q[FLAG_P2_DOT]) pix = COL_P2;
            else if (x_q >= coord_t'(MINIMAP_X0) && x_q < coord_t'(MINIMAP_X1))
                pix = PALETTE[mini_cell];
            else pix = COL_HUD;
        end
        else if (x_q == coord_t'(HALF_W - 1) || x_q == coord_t'(HALF_W)) pix = COL_SEPARATOR;
        else if (tinted) pix = left_q ? COL_P1_WIN : COL_P2_WIN;  // finished side
        else if (flags_q[FLAG_SELF_BOX]) pix = left_q ? COL_P1 : COL_P2;
        else if (flags_q[FLAG_ENEMY_BOX]) pix = left_q ? COL_P2 : COL_P1;
        else if (flags_q[FLAG_OUT_OF_MAP]) pix = COL_OUT_BOUND;
        else pix = PALETTE[view_cell];
    end

    // stage two
    always_ff @(posedge clk_25MHz) begin
        if (rst) rgb <= '0;
        else rgb <= pix;
    end

    assign hsync = hs_pipe[PIPE_LATENCY-1];
    assign vsync = vs_pipe[PIPE_LATENCY-1];

endmodule

/* logic/race_display_top.sv */
`timescale 1ns/10ps

module race_display_top import race_pkg::*; #(
    parameter int COUNT_TICKS = 25_000_000
) (
    input  logic       clk_25MHz,
    input  logic       rst,
    input  logic       start_btn,
    input  logic       setting_btn,
    input  logic       pause_btn,
    input  logic       p1_finish,
    input  logic       p2_finish,
    input  coord_t     p1_x,
    input  coord_t     p1_y,
    input  coord_t     p2_x,
    input  coord_t     p2_y,
    // host access to the track map
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  cell_addr_t wb_adr,
    input  logic [7:0] wb_wdata,
    output logic [7:0] wb_rdata,
    output logic       wb_ack,
    output logic [3:0] vga_red,
    output logic [3:0] vga_green,
    output logic [3:0] vga_blue,
    output logic       hsync,
    output logic       vsync,
    output logic [2:0] led
);

    scan_if      scan_bus ();
    game_state_t state;
    logic        hsync_raw, vsync_raw;
    cell_addr_t  view_addr, mini_addr;
    cell_color_t view_cell, mini_cell;
    logic [4:0]  flags;
    rgb_t        rgb;

    vga_timing i_vga_timing (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .scan      (scan_bus),
        .hsync     (hsync_raw),
        .vsync     (vsync_raw)
    );

    game_fsm #(.COUNT_TICKS(COUNT_TICKS)) i_game_fsm (
        .clk_25MHz   (clk_25MHz),
        .rst         (rst),
        .start_btn   (start_btn),
        .setting_btn (setting_btn),
        .pause_btn   (pause_btn),
        .p1_finish   (p1_finish),
        .p2_finish   (p2_finish),
        .state       (state)
    );

    view_addr_gen i_view_addr_gen (
        .scan      (scan_bus),
        .p1_x      (p1_x),
        .p1_y      (p1_y),
        .p2_x      (p2_x),
        .p2_y      (p2_y),
        .view_addr (view_addr),
        .mini_addr (mini_addr),
        .flags     (flags)
    );

    map_ram i_map_ram (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .view_addr (view_addr),
        .mini_addr (mini_addr),
        .view_cell (view_cell),
        .mini_cell (mini_cell),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack)
    );

    pixel_mixer i_pixel_mixer (
        .clk_25MHz (clk_25MHz),
        .rst       (rst),
        .scan      (scan_bus),
        .hsync_raw (hsync_raw),
        .vsync_raw (vsync_raw),
        .state     (state),
        .p1_finish (p1_finish),
        .p2_finish (p2_finish),
        .flags     (flags),
        .view_cell (view_cell),
        .mini_cell (mini_cell),
        .rgb       (rgb),
        .hsync     (hsync),
        .vsync     (vsync)
    );

    assign vga_red   = rgb[11:8];
    assign vga_green = rgb[7:4];
    assign vga_blue  = rgb[3:0];
    assign led       = state;  // raw state code

endmodule

/* verif/race_display_tb.sv */
`timescale 1ns/10ps

module race_display_tb;

    localparam int         COUNT_TICKS    = 50;
    localparam int         FRAME_CYCLES   = 800 * 525;
    localparam int         TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 2000;
    localparam int         HS_WIDTH       = 96;
    localparam logic [9:0] X_LAST         = 10'd799;
    localparam logic [9:0] Y_LAST         = 10'd524;
    localparam logic [9:0] HS_FIRST       = 10'd656;
    localparam logic [9:0] HS_END         = 10'd752;
    localparam logic [9:0] VS_FIRST       = 10'd490;
    localparam logic [9:0] VS_END         = 10'd492;

    logic        clk_25MHz, rst;
    logic        start_btn, setting_btn, pause_btn;
    logic        p1_finish, p2_finish;
    logic [9:0]  p1_x, p1_y, p2_x, p2_y;
    logic        wb_cyc, wb_stb, wb_we;
    logic [12:0] wb_adr;
    logic [7:0]  wb_wdata, wb_rdata;
    logic        wb_ack;
    logic [3:0]  vga_red, vga_green, vga_blue;
    logic        hsync, vsync;
    logic [2:0]  led;

    logic [9:0]  tb_x, tb_y;        // model of the scan counters
    logic [9:0]  x_d1, x_d2, y_d1, y_d2;
    int          run_cycles = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          sync_errors = 0;
    int          hs_run = 0;
    int          vs_low_cycles = 0;

    race_display_top #(.COUNT_TICKS(COUNT_TICKS)) i_dut (
        .clk_25MHz   (clk_25MHz),
        .rst         (rst),
        .start_btn   (start_btn),
        .setting_btn (setting_btn),
        .pause_btn   (pause_btn),
        .p1_finish   (p1_finish),
        .p2_finish   (p2_finish),
        .p1_x        (p1_x),
        .p1_y        (p1_y),
        .p2_x        (p2_x),
        .p2_y        (p2_y),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_wdata    (wb_wdata),
        .wb_rdata    (wb_rdata),
        .wb_ack      (wb_ack),
        .vga_red     (vga_red),
        .vga_green   (vga_green),
        .vga_blue    (vga_blue),
        .hsync       (hsync),
        .vsync       (vsync),
        .led         (led)
    );

    initial begin
        clk_25MHz = 1'b0;
        forever #20 clk_25MHz = ~clk_25MHz;
    end

    // 800 x 525 scan that is zero in the cycle after reset falls
    always @(posedge clk_25MHz) begin
        run_cycles <= run_cycles + 1;
        if (rst) begin
            tb_x <= '0;
            tb_y <= '0;
        end else if (tb_x == X_LAST) begin
            tb_x <= '0;
            tb_y <= (tb_y == Y_LAST) ? 10'd0 : tb_y + 10'd1;
        end else begin
            tb_x <= tb_x + 10'd1;
        end
        x_d1 <= tb_x;
        x_d2 <= x_d1;   // position behind the outputs
        y_d1 <= tb_y;
        y_d2 <= y_d1;
    end

    always @(negedge clk_25MHz) begin : sync_monitor
        logic exp_hs;
        logic exp_vs;
        if (run_cycles >= 3) begin
            exp_hs = !(x_d2 >= HS_FIRST && x_d2 < HS_END);
            exp_vs = !(y_d2 >= VS_FIRST && y_d2 < VS_END);
            assert (hsync == exp_hs) else begin
                $display("** Error at %0t: hsync = %b, expected %b", $time, hsync, exp_hs);
                sync_errors++;
            end
            assert (vsync == exp_vs) else begin
                $display("** Error at %0t: vsync = %b, expected %b", $time, vsync, exp_vs);
                sync_errors++;
            end
            if (!hsync) begin
                hs_run++;
            end else begin
                if (hs_run != 0) begin
                    assert (hs_run == HS_WIDTH) else begin
                        $display("hsync pulse lasted %0d cycles instead of %0d", hs_run, HS_WIDTH);
                        sync_errors++;
                    end
                end
                hs_run = 0;
            end
            if (!vsync) vs_low_cycles++;
        end
    end

    task automatic wb_access(input logic we, input logic [12:0] adr, input logic [7:0] wdata,
                             input logic [7:0] exp);
        int waited;
        waited = 0;
        @(posedge clk_25MHz);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_wdata <= wdata;
        @(negedge clk_25MHz);
        while (!wb_ack && waited < 16) begin
            waited++;
            @(negedge clk_25MHz);
        end
        if (!wb_ack) begin
            $display("no Wishbone ack for address %0d within 16 cycles", adr);
            other_errors++;
        end else begin
            assert (waited == 1) else begin
                $display("Wishbone ack came %0d cycles after the strobe, not 1", waited);
                other_errors++;
            end
            if (!we) begin
                assert (wb_rdata == exp) else begin
                    $display("** Error at %0t: wb_rdata = %h, expected %h", $time, wb_rdata, exp);
                    value_errors++;
                end
            end
        end
        @(posedge clk_25MHz);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk_25MHz);
        assert (!wb_ack) else begin
            $display("Wishbone ack stayed high for more than one cycle");
            other_errors++;
        end
    endtask

    task automatic pulse_button(input logic [63:0] which);
        @(posedge clk_25MHz);
        if (which == 64'("start")) start_btn <= 1'b1;
        else if (which == 64'("setting")) setting_btn <= 1'b1;
        else if (which == 64'("pause")) pause_btn <= 1'b1;
        else begin
            $display("unknown button name in stimulus file");
            other_errors++;
        end
        @(posedge clk_25MHz);
        start_btn   <= 1'b0;
        setting_btn <= 1'b0;
        pause_btn   <= 1'b0;
    endtask

    task automatic check_state(input logic [2:0] code, input int min_wait, input int max_wait);
        int waited;
        waited = 0;
        @(negedge clk_25MHz);
        while (led != code && waited < max_wait) begin
            waited++;
            @(negedge clk_25MHz);
        end
        assert (led == code) else begin
            $display("** Error at %0t: led = %0d, expected %0d", $time, led, code);
            value_errors++;
        end
        if (led == code) begin
            assert (waited >= min_wait) else begin
                $display("state %0d reached after %0d cycles, sooner than %0d",
                         code, waited, min_wait);
                other_errors++;
            end
        end
    endtask

    task automatic check_pixel(input logic [9:0] px, input logic [9:0] py,
                               input logic [11:0] exp);
        int          guard;
        logic [11:0] rgb_seen;
        guard = 0;
        @(negedge clk_25MHz);
        while (!(tb_x == px && tb_y == py) && guard <= FRAME_CYCLES) begin
            guard++;
            @(negedge clk_25MHz);
        end
        if (guard > FRAME_CYCLES) begin
            $display("scan never reached pixel (%0d, %0d)", px, py);
            other_errors++;
        end else begin
            repeat (2) @(negedge clk_25MHz);  // two-stage pixel pipeline
            rgb_seen = {vga_red, vga_green, vga_blue};
            assert (rgb_seen == exp) else begin
                $display("** Error at %0t: rgb = %h, expected %h at pixel (%0d, %0d)",
                         $time, rgb_seen, exp, px, py);
                value_errors++;
            end
        end
    endtask

    initial begin : main_sequence
        int               fd, code, a, b, c, d;
        logic [7:0]       cmd;
        logic [63:0]      name;
        logic [8*128-1:0] rest_of_line;
        rst         <= 1'b1;
        start_btn   <= 1'b0;
        setting_btn <= 1'b0;
        pause_btn   <= 1'b0;
        p1_finish   <= 1'b0;
        p2_finish   <= 1'b0;
        p1_x        <= '0;
        p1_y        <= '0;
        p2_x        <= '0;
        p2_y        <= '0;
        wb_cyc      <= 1'b0;
        wb_stb      <= 1'b0;
        wb_we       <= 1'b0;
        wb_adr      <= '0;
        wb_wdata    <= '0;
        repeat (4) @(posedge clk_25MHz);
        rst <= 1'b0;

        fd = $fopen("verif/race_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            other_errors++;
        end else begin
            code = $fscanf(fd, " %c", cmd);
            while (code == 1) begin
                case (cmd)
                    "#": code = $fgets(rest_of_line, fd);   // comment line
                    "W": begin
                        code = $fscanf(fd, "%d %h", a, b);
                        wb_access(1'b1, 13'(a), 8'(b), 8'h00);
                    end
                    "R": begin
                        code = $fscanf(fd, "%d %h", a, b);
                        wb_access(1'b0, 13'(a), 8'h00, 8'(b));
                    end
                    "B": begin
                        name = '0;
                        code = $fscanf(fd, " %s", name);
                        pulse_button(name);
                    end
                    "S": begin
                        code = $fscanf(fd, "%d %d %d", a, b, c);
                        check_state(3'(a), b, c);
                    end
                    "P": begin
                        code = $fscanf(fd, "%d %d %d %d", a, b, c, d);
                        @(posedge clk_25MHz);
                        p1_x <= 10'(a);
                        p1_y <= 10'(b);
                        p2_x <= 10'(c);
                        p2_y <= 10'(d);
                    end
                    "F": begin
                        code = $fscanf(fd, "%d %d", a, b);
                        @(posedge clk_25MHz);
                        p1_finish <= (a != 0);
                        p2_finish <= (b != 0);
                    end
                    "C": begin
                        code = $fscanf(fd, "%d %d %h", a, b, c);
                        check_pixel(10'(a), 10'(b), 12'(c));
                    end
                    default: begin
                        $display("unknown command '%c' in stimulus file", cmd);
                        other_errors++;
                    end
                endcase
                code = $fscanf(fd, " %c", cmd);
            end
            $fclose(fd);
        end

        assert (vs_low_cycles > 0) else begin
            $display("vsync never went low during the run");
            other_errors++;
        end
        $display("errors: %0d value, %0d protocol, %0d sync",
                 value_errors, other_errors, sync_errors);
        if (value_errors + other_errors + sync_errors == 0) $display("Test OK");
        else $display("Test FAILED");
        $finish;
    end

    initial begin : watchdog
        while (run_cycles < TIMEOUT_CYCLES) @(posedge clk_25MHz);
        $display("timeout, stimulus not finished after %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d value, %0d protocol, %0d sync",
                 value_errors, other_errors, sync_errors);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* flist.f */
logic/race_pkg.sv
logic/scan_if.sv
logic/vga_timing.sv
logic/game_fsm.sv
logic/map_ram.sv
logic/view_addr_gen.sv
logic/pixel_mixer.sv
logic/race_display_top.sv
verif/race_display_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= race_display_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf $(OBJ_DIR)

/* verif/race_stimulus.txt */
# W adr data, R adr expected, B button, S state min_wait max_wait, C x y rgb
# P p1x p1y p2x p2y, F p1 p2; adr and coordinates decimal, data and rgb hex
W 322 3D
W 1630 FF
W 4799 06
R 322 01
R 1630 03
R 4799 02
P 20 20 40 30
C 100 2 BEB
B setting
S 1 0 3
B setting
S 0 0 3
B setting
S 1 0 3
B start
S 3 0 3
S 4 145 155
B pause
S 5 0 3
B pause
S 4 0 3
# racing views, first frame in scan order
C 20 20 6B4
C 319 100 FFF
C 400 140 F00
C 160 180 F00
C 480 180 00F
C 400 200 2A2
C 250 240 00F
C 600 300 888
C 100 359 FFF
C 245 365 F00
C 100 400 444
C 300 400 000
# second frame, finish flags
F 1 0
C 100 100 FAA
C 400 200 2A2
F 1 1
S 6 0 3
C 500 300 222
B start
S 0 0 3
